// ==== files.f ====
hw/board_pkg.sv
hw/score_pkg.sv
hw/material_eval.sv
hw/phase_count.sv
hw/taper_blend.sv
hw/eval_control.sv
hw/board_eval.sv
test/board_eval_assertions.sv
test/board_eval_tb.sv

// ==== test/board_eval_tb.sv ====
`timescale 1ns/1ps
/* Testbench for board_eval at a 16-bit score. Random boards use legal piece codes
   0 to 6 only; expected scores are built from the material, phase and blend rules */
module board_eval_tb;
   import board_pkg::*;

   localparam int     EVAL_WIDTH     = 16;
   localparam int     NUM_RANDOM     = 30;            // Random boards
   localparam int     TIMEOUT_CYCLES = 40 * (NUM_RANDOM + 10);
   localparam int     PHASE_LIMIT    = 62;
   localparam longint BLEND_MUL      = 16912;         // floor(2^20 / 62)
   localparam longint BLEND_DIV      = 64'd1 << 20;

   logic                         clk = 1'b0;
   logic                         reset;
   board_t                       board_in;
   logic                         board_valid;
   logic                         attack_done;
   logic                         clear_eval;
   logic signed [EVAL_WIDTH-1:0] eval;
   logic                         eval_valid;

   integer seed            = 32'h740207e5;
   int     value_errors    = 0;
   int     protocol_errors = 0;
   int     cycles          = 0;

   board_eval #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_board_eval
   (
      .clk         (clk),
      .reset       (reset),
      .board_in    (board_in),
      .board_valid (board_valid),
      .attack_done (attack_done),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   always #2 clk = ~clk;                              // 4 ns period

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // Inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   function automatic longint piece_value(input int code, input bit endgame);
      case (code)
         1:       return endgame ? 94 : 82;           // Pawn
         2:       return endgame ? 281 : 337;         // Knight
         3:       return endgame ? 297 : 365;         // Bishop
         4:       return endgame ? 512 : 477;         // Rook
         5:       return endgame ? 936 : 1025;        // Queen
         default: return 0;                           // Empty or king
      endcase
   endfunction

   task automatic reference_eval(input board_t b,
                                 output logic signed [EVAL_WIDTH-1:0] expected);
      longint mg;
      longint eg;
      longint blended;
      int     phase;
      mg    = 0;
      eg    = 0;
      phase = 0;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         mg += (b[sq].black ? -1 : 1) * piece_value(int'(b[sq].kind), 1'b0);
         eg += (b[sq].black ? -1 : 1) * piece_value(int'(b[sq].kind), 1'b1);
         if (b[sq].kind != EMPTY && b[sq].kind != PAWN)
            phase++;                                  // Kings count too
      end
      if (phase > PHASE_LIMIT)
         phase = PHASE_LIMIT;
      blended  = (mg * phase + eg * (PHASE_LIMIT - phase)) * BLEND_MUL;
      expected = EVAL_WIDTH'(blended / BLEND_DIV);    // Division rounds toward zero
   endtask

   task automatic make_start_board(output board_t b);
      piece_type_e back [8] = '{ROOK, KNIGHT, BISHOP, QUEEN, KING, BISHOP, KNIGHT, ROOK};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f]      = '{1'b0, back[f]};                // White back rank
         b[8 + f]  = '{1'b0, PAWN};
         b[48 + f] = '{1'b1, PAWN};
         b[56 + f] = '{1'b1, back[f]};                // Black back rank
      end
   endtask

   task automatic make_random_board(output board_t b);
      int         r;
      logic [2:0] code;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         r    = $random(seed);
         code = r[2:0];
         if (code == 3'd7)
            code = 3'd0;                              // Extra empties
         b[sq].black = r[3];
         b[sq].kind  = piece_type_e'(code);
      end
   endtask

   task automatic check_value(input string name, input logic signed [EVAL_WIDTH-1:0] got,
                              input logic signed [EVAL_WIDTH-1:0] expected);
      assert (got === expected)
      else
      begin
         value_errors++;
         $display("ERR %0t: %s gave eval %0d, expected %0d", $time, name, got, expected);
      end
   endtask

   // One full evaluation ended by clear_eval
   task automatic evaluate(input board_t b, input int attack_delay, input bit keep_valid,
                           output logic signed [EVAL_WIDTH-1:0] got);
      board_in    = b;
      board_valid = 1'b1;
      step();                                         // Capture edge
      if (!keep_valid)
         board_valid = 1'b0;
      repeat (attack_delay)
         step();
      attack_done = 1'b1;
      while (!eval_valid)
         step();
      got         = eval;
      attack_done = 1'b0;
      repeat (2)
         step();                                      // Hold a little before clearing
      clear_eval = 1'b1;
      step();
      clear_eval = 1'b0;
   endtask

   initial
   begin
      board_t                       b;
      logic signed [EVAL_WIDTH-1:0] got;
      logic signed [EVAL_WIDTH-1:0] expected;
      int                           r;
      int                           assertion_failures;
      reset       = 1'b1;
      board_in    = '0;
      board_valid = 1'b0;
      attack_done = 1'b0;
      clear_eval  = 1'b0;
      repeat (10)
         step();
      reset = 1'b0;
      step();

      make_start_board(b);
      evaluate(b, 1, 1'b0, got);
      check_value("start position", got, '0);         // Material cancels out

      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         make_random_board(b);
         r = $random(seed);
         reference_eval(b, expected);
         evaluate(b, int'(r[7:0]) % 6, 1'b0, got);    // attack_done after 0 to 5 cycles
         check_value($sformatf("random board %0d", i), got, expected);
      end

      for (int sq = 0; sq < NUM_SQUARES; sq++)
         b[sq] = '{1'b0, KNIGHT};                     // 64 officers clamp the phase
      reference_eval(b, expected);
      evaluate(b, 0, 1'b0, got);
      check_value("all knights", got, expected);

      // board_valid stays high across the clear
      make_random_board(b);
      reference_eval(b, expected);
      evaluate(b, 2, 1'b1, got);
      check_value("held board_valid", got, expected);
      attack_done = 1'b1;
      repeat (16)
      begin
         step();
         assert (!eval_valid)
         else
         begin
            protocol_errors++;
            $display("ERR %0t: eval_valid rose again while board_valid was still held high",
                     $time);
         end
      end
      attack_done = 1'b0;
      board_valid = 1'b0;
      step();
      make_random_board(b);
      reference_eval(b, expected);
      evaluate(b, 0, 1'b0, got);                      // Fresh edge runs again
      check_value("board after release", got, expected);

      assertion_failures = u_board_eval.u_board_eval_assertions.failures;
      $display("value errors: %0d, protocol errors: %0d, assertion failures: %0d",
               value_errors, protocol_errors, assertion_failures);
      if (value_errors + protocol_errors + assertion_failures == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== test/board_eval_assertions.sv ====
`timescale 1ns/1ps
/* Control protocol checks bound to every board_eval instance. Assumes
   eval_valid is high exactly while the FSM is in hold */
module board_eval_assertions
#(
   parameter int EVAL_WIDTH = 16
)
(
   input logic                         clk,
   input logic                         reset,
   input logic                         board_valid,
   input logic                         attack_done,
   input logic                         clear_eval,
   input logic                         eval_valid,
   input logic signed [EVAL_WIDTH-1:0] eval,
   input score_pkg::eval_state_e       state
);
   import score_pkg::*;

   int unsigned failures = 0;                         // Failed checks so far

   reset_low: assert property (@(posedge clk) reset |=> !eval_valid)
   else
   begin
      failures++;
      $error("eval_valid was high right after a reset cycle");
   end

   release_low: assert property (@(posedge clk) $fell(reset) |=> !eval_valid)
   else
   begin
      failures++;
      $error("eval_valid was high in the cycle after reset was released");
   end

   // No result until attack_done moves the FSM on
   attack_wait: assert property (@(posedge clk) disable iff (reset)
      state == WAIT_ATTACK && !attack_done |=> state == WAIT_ATTACK && !eval_valid)
   else
   begin
      failures++;
      $error("the FSM left the attack wait or raised eval_valid before attack_done");
   end

   hold_stable: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid && $stable(eval))
   else
   begin
      failures++;
      $error("eval or eval_valid changed in hold without clear_eval");
   end

   clear_drops: assert property (@(posedge clk) disable iff (reset)
      eval_valid && clear_eval |=> !eval_valid)
   else
   begin
      failures++;
      $error("eval_valid did not fall one cycle after clear_eval");
   end

   // Held board_valid is a level, not a new edge
   no_retrigger: assert property (@(posedge clk) disable iff (reset)
      state == IDLE && board_valid && $past(board_valid) |=> state == IDLE)
   else
   begin
      failures++;
      $error("a held board_valid started a second evaluation");
   end

endmodule

bind board_eval board_eval_assertions #(
   .EVAL_WIDTH (EVAL_WIDTH)
) u_board_eval_assertions
(
   .clk         (clk),
   .reset       (reset),
   .board_valid (board_valid),
   .attack_done (attack_done),
   .clear_eval  (clear_eval),
   .eval_valid  (eval_valid),
   .eval        (eval),
   .state       (u_eval_control.state)
);

// ==== hw/board_eval.sv ====
`timescale 1ns/1ps
/* Material and phase board evaluator, score always from white's side. eval is valid
   only while eval_valid is high; board_in is sampled on the board_valid edge */
module board_eval
#(
   parameter int EVAL_WIDTH = 16                      // Output score width
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  board_pkg::board_t            board_in,
   input  logic                         board_valid,
   input  logic                         attack_done,
   input  logic                         clear_eval,
   output logic signed [EVAL_WIDTH-1:0] eval,
   output logic                         eval_valid
);
   import board_pkg::*;
   import score_pkg::*;

   board_t                 board;                     // Captured position
   logic                   capture;
   logic                   start;
   logic                   clear;
   logic                   material_done;
   logic                   phase_done;
   score_pair_t            material;                  // mg and eg sums
   logic [PHASE_WIDTH-1:0] phase;

   always_ff @(posedge clk)
   begin
      if (capture)
         board <= board_in;
   end

   eval_control u_eval_control
   (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .attack_done   (attack_done),
      .clear_eval    (clear_eval),
      .material_done (material_done),
      .phase_done    (phase_done),
      .capture       (capture),
      .start         (start),
      .clear         (clear),
      .eval_valid    (eval_valid)
   );

   material_eval u_material_eval
   (
      .clk      (clk),
      .reset    (reset),
      .board    (board),
      .start    (start),
      .clear    (clear),
      .material (material),
      .done     (material_done)
   );

   phase_count u_phase_count
   (
      .clk   (clk),
      .reset (reset),
      .board (board),
      .start (start),
      .clear (clear),
      .phase (phase),
      .done  (phase_done)
   );

   taper_blend #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_taper_blend
   (
      .clk      (clk),
      .material (material),
      .phase    (phase),
      .eval     (eval)
   );

endmodule

// ==== hw/eval_control.sv ====
`timescale 1ns/1ps
/* Evaluation sequencer. Acts on a board_valid rising edge only, so a held level never
   starts a second run; eval_valid holds until clear_eval is seen in hold */
module eval_control
(
   input  logic clk,
   input  logic reset,
   input  logic board_valid,
   input  logic attack_done,
   input  logic clear_eval,
   input  logic material_done,
   input  logic phase_done,
   output logic capture,
   output logic start,
   output logic clear,
   output logic eval_valid
);
   import score_pkg::*;

   localparam int DRAIN_WIDTH = $clog2(BLEND_LATENCY) + 1;

   eval_state_e            state;
   logic                   board_valid_r;             // For edge detection
   logic [DRAIN_WIDTH-1:0] drain_cnt;                 // Cycles spent in wait_drain

   // Board loads on the edge itself
   assign capture = (state == IDLE) && board_valid && !board_valid_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= IDLE;
         board_valid_r <= 1'b0;
         drain_cnt     <= '0;
         start         <= 1'b0;
         clear         <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         start         <= 1'b0;                       // Single-cycle pulses
         clear         <= 1'b0;
         case (state)
            IDLE:
            begin
               drain_cnt <= '0;
               if (capture)
                  state <= WAIT_ATTACK;
            end
            WAIT_ATTACK:
            begin
               if (attack_done)
               begin
                  start <= 1'b1;                      // Kick both evaluators
                  state <= WAIT_EVAL;
               end
            end
            WAIT_EVAL:
            begin
               if (material_done && phase_done)
                  state <= WAIT_DRAIN;
            end
            WAIT_DRAIN:
            begin
               drain_cnt <= drain_cnt + 1'b1;
               if (drain_cnt == DRAIN_WIDTH'(BLEND_LATENCY - 1))
               begin
                  state      <= HOLD;                 // Blend output now settled
                  eval_valid <= 1'b1;
               end
            end
            HOLD:
            begin
               if (clear_eval)
               begin
                  state      <= IDLE;
                  eval_valid <= 1'b0;
                  clear      <= 1'b1;                 // Drops the done levels
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

// ==== hw/taper_blend.sv ====
`timescale 1ns/1ps
/* Tapered blend, five stages, accepts new inputs every cycle. The result wraps if it
   does not fit EVAL_WIDTH; phase above 62 gives a wrong endgame weight */
module taper_blend
#(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                              clk,
   input  score_pkg::score_pair_t            material,
   input  logic [score_pkg::PHASE_WIDTH-1:0] phase,
   output logic signed [EVAL_WIDTH-1:0]      eval
);
   import score_pkg::*;

   localparam int WEIGHT_WIDTH = PHASE_WIDTH + 1;           // Signed 0 to 62
   localparam int PROD_WIDTH   = ACC_WIDTH + WEIGHT_WIDTH;  // Score times weight
   localparam int SUM_WIDTH    = PROD_WIDTH + 1;
   localparam int MUL_WIDTH    = $clog2(SCALE_MUL + 1) + 1; // Signed scale factor
   localparam int SCALED_WIDTH = SUM_WIDTH + MUL_WIDTH;
   localparam int QUOT_WIDTH   = SCALED_WIDTH - SCALE_SHIFT;

   localparam logic signed [MUL_WIDTH-1:0]    SCALE      = MUL_WIDTH'(SCALE_MUL);
   localparam logic signed [SCALED_WIDTH-1:0] ROUND_BIAS = (SCALED_WIDTH'(1) << SCALE_SHIFT) - 1;

   logic signed [WEIGHT_WIDTH-1:0] mg_weight, eg_weight;
   logic signed [PROD_WIDTH-1:0]   mg_term, eg_term;   // Stage 1
   logic signed [SUM_WIDTH-1:0]    blend_sum;          // Stage 2
   logic signed [SCALED_WIDTH-1:0] scaled;             // Stage 3
   logic signed [SCALED_WIDTH-1:0] rounded;
   logic signed [QUOT_WIDTH-1:0]   quotient;           // Stage 4

   // Phase weights, mg by p, eg by 62 minus p
   always_comb
   begin
      mg_weight = $signed({1'b0, phase});
      eg_weight = WEIGHT_WIDTH'(PHASE_MAX - phase);
   end

   // Negative values biased so the shift rounds toward zero
   always_comb
   begin
      if (scaled[SCALED_WIDTH-1])
         rounded = scaled + ROUND_BIAS;
      else
         rounded = scaled;
   end

   always_ff @(posedge clk)
   begin
      mg_term   <= $signed(material.mg) * mg_weight;
      eg_term   <= $signed(material.eg) * eg_weight;
      blend_sum <= mg_term + eg_term;
      scaled    <= blend_sum * SCALE;                  // Approximates division by 62
      quotient  <= QUOT_WIDTH'(rounded >>> SCALE_SHIFT);
      eval      <= EVAL_WIDTH'(quotient);              // Truncate or sign-extend
   end

endmodule

// ==== hw/phase_count.sv ====
`timescale 1ns/1ps
/* Game phase from the count of non-pawn pieces, kings included, clamped to 62.
   Any code other than empty or pawn counts */
module phase_count
(
   input  logic                              clk,
   input  logic                              reset,
   input  board_pkg::board_t                 board,
   input  logic                              start,
   input  logic                              clear,
   output logic [score_pkg::PHASE_WIDTH-1:0] phase,
   output logic                              done
);
   import board_pkg::*;
   import score_pkg::*;

   localparam int HALF       = NUM_SQUARES / 2;
   localparam int HALF_WIDTH = $clog2(HALF + 1);     // Counts 0 to 32

   logic [NUM_SQUARES-1:0] officer_mask;             // Non-empty, non-pawn squares
   logic [HALF_WIDTH-1:0]  count_lo_next, count_hi_next;
   logic [HALF_WIDTH-1:0]  count_lo, count_hi;       // Stage one
   logic [HALF_WIDTH:0]    count_sum;                // Whole board, up to 64
   logic                   start_d;

   always_comb
   begin
      for (int sq = 0; sq < NUM_SQUARES; sq++)
         officer_mask[sq] = (board[sq].kind != EMPTY) && (board[sq].kind != PAWN);
   end

   // Population count, low and high half separately
   always_comb
   begin
      count_lo_next = '0;
      count_hi_next = '0;
      for (int i = 0; i < HALF; i++)
      begin
         count_lo_next = count_lo_next + HALF_WIDTH'(officer_mask[i]);
         count_hi_next = count_hi_next + HALF_WIDTH'(officer_mask[HALF + i]);
      end
   end

   assign count_sum = count_lo + count_hi;

   always_ff @(posedge clk)
   begin
      count_lo <= count_lo_next;
      count_hi <= count_hi_next;
      if (count_sum > PHASE_MAX)                      // Clamp at the phase limit
         phase <= PHASE_WIDTH'(PHASE_MAX);
      else
         phase <= count_sum[PHASE_WIDTH-1:0];
   end

   // Same two-cycle done as the material sum
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_d <= 1'b0;
         done    <= 1'b0;
      end
      else
      begin
         start_d <= start;
         if (clear)
            done <= 1'b0;
         else if (start_d)
            done <= 1'b1;
      end
   end

endmodule

// ==== hw/material_eval.sv ====
`timescale 1ns/1ps
/* Sums signed material in two register stages. The board must stay steady from
   start until done; material is only meaningful while done is high */
module material_eval
(
   input  logic                   clk,
   input  logic                   reset,
   input  board_pkg::board_t      board,
   input  logic                   start,
   input  logic                   clear,
   output score_pkg::score_pair_t material,
   output logic                   done
);
   import board_pkg::*;
   import score_pkg::*;

   localparam int GROUPS     = 8;                    // One group per rank
   localparam int GROUP_SIZE = NUM_SQUARES / GROUPS;

   score_pair_t square_value [NUM_SQUARES];          // Signed value per square
   score_pair_t group_next   [GROUPS];               // Rank sums before stage one
   score_pair_t group_sum    [GROUPS];               // Stage one registers
   score_pair_t total_next;                          // Board sum before stage two
   logic        start_d;                             // Start delayed one cycle

   // Table lookup, black pieces negated
   always_comb
   begin
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         square_value[sq] = PIECE_VALUE[board[sq].kind];
         if (board[sq].black)
         begin
            square_value[sq].mg = -PIECE_VALUE[board[sq].kind].mg;
            square_value[sq].eg = -PIECE_VALUE[board[sq].kind].eg;
         end
      end
   end

   // Eight squares per group
   always_comb
   begin
      for (int g = 0; g < GROUPS; g++)
      begin
         group_next[g] = '0;
         for (int k = 0; k < GROUP_SIZE; k++)
         begin
            group_next[g].mg = group_next[g].mg + square_value[g*GROUP_SIZE + k].mg;
            group_next[g].eg = group_next[g].eg + square_value[g*GROUP_SIZE + k].eg;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      group_sum <= group_next;                        // Stage one
   end

   // Fold the eight group results
   always_comb
   begin
      total_next = '0;
      for (int g = 0; g < GROUPS; g++)
      begin
         total_next.mg = total_next.mg + group_sum[g].mg;
         total_next.eg = total_next.eg + group_sum[g].eg;
      end
   end

   always_ff @(posedge clk)
   begin
      material <= total_next;                         // Stage two
   end

   // Done two cycles after start, held until clear
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_d <= 1'b0;
         done    <= 1'b0;
      end
      else
      begin
         start_d <= start;
         if (clear)
            done <= 1'b0;
         else if (start_d)
            done <= 1'b1;
      end
   end

endmodule

// ==== hw/score_pkg.sv ====
/* Score arithmetic constants and control states. Material sums are 20 bits signed,
   which covers any board of 64 legal pieces with room to spare */
package score_pkg;

   localparam int ACC_WIDTH = 20;     // Width of mg and eg material sums

   // Middlegame and endgame scores travel together
   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] mg;
      logic signed [ACC_WIDTH-1:0] eg;
   } score_pair_t;

   // White piece values by piece code, black is the negation
   localparam score_pair_t PIECE_VALUE [8] = '{
      '{mg:    0, eg:   0},          // Empty
      '{mg:   82, eg:  94},          // Pawn
      '{mg:  337, eg: 281},          // Knight
      '{mg:  365, eg: 297},          // Bishop
      '{mg:  477, eg: 512},          // Rook
      '{mg: 1025, eg: 936},          // Queen
      '{mg:    0, eg:   0},          // King, no material weight
      '{mg:    0, eg:   0}           // Code 7 unused
   };

   // Game phase
   localparam int PHASE_MAX   = 62;  // Clamp for the non-pawn count
   localparam int PHASE_WIDTH = 6;   // Holds 0 to 62

   // Division by 62 done as multiply then shift
   localparam int SCALE_SHIFT = 20;
   localparam int SCALE_MUL   = (1 << SCALE_SHIFT) / PHASE_MAX;   // 16912, floored

   localparam int BLEND_LATENCY = 5; // Register stages in the blend pipeline

   // Control sequence
   typedef enum logic [2:0] {
      IDLE        = 3'd0,            // Waiting for a board_valid edge
      WAIT_ATTACK = 3'd1,            // Board captured, attack tables pending
      WAIT_EVAL   = 3'd2,            // Evaluators running
      WAIT_DRAIN  = 3'd3,            // Blend pipeline filling
      HOLD        = 3'd4             // Result presented until clear_eval
   } eval_state_e;

endpackage

// ==== hw/board_pkg.sv ====
/* Board encoding shared by the evaluator and its testbench. Piece code 7 is not a legal
   piece: it scores no material but still counts toward the game phase */
package board_pkg;

   // Piece type codes, 0 to 6
   typedef enum logic [2:0] {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_type_e;

   // One square, 4 bits
   typedef struct packed {
      logic        black;       // 1 for a black piece
      piece_type_e kind;        // Piece type on the square
   } piece_t;

   localparam int NUM_SQUARES = 64;   // Full 8x8 board

   // Square 0 sits in the low nibble
   typedef piece_t [NUM_SQUARES-1:0] board_t;

endpackage
